/* design/next_line_pred.sv */
// instruction-side next-line predictor
// proposes the line after each fetched line, one candidate per new line
`timescale 1ns/10ps

module next_line_pred
    import prefetch_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  fetch_valid,
    input  addr_t fetch_addr,
    output logic  inst_cand_valid,
    output addr_t inst_cand_addr
);

    addr_t next_line;
    addr_t last_line;
    logic  propose;

    // start of the following line
    assign next_line = {fetch_addr[ADDR_W-1:LINE_OFF_W], LINE_OFF_W'(0)}
                       + addr_t'(LINE_BYTES);

    // repeat filter against the last proposed line
    assign propose = fetch_valid && (next_line != last_line);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            inst_cand_valid <= 1'b0;
            last_line       <= NO_LINE;
        end else begin
            inst_cand_valid <= propose;
            if (propose) begin
                last_line <= next_line;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (propose) begin
            inst_cand_addr <= next_line;
        end
    end

endmodule

/* design/prefetch_issue.sv */
// merges instruction and data candidates into L2 prefetch requests
// one slot per source, data first, credit-based flow control toward the L2
`timescale 1ns/10ps

module prefetch_issue
    import prefetch_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       inst_cand_valid,
    input  addr_t      inst_cand_addr,
    input  logic       data_cand_valid,
    input  addr_t      data_cand_addr,
    input  logic       credit_return,
    output logic       pref_valid,
    output addr_t      pref_addr,
    output pref_kind_e pref_kind
);

    issue_state_e state;
    issue_state_e state_next;

    logic    inst_full;
    logic    data_full;
    addr_t   inst_slot;
    addr_t   data_slot;

    credit_t credit_cnt;
    credit_t credit_next;

    logic    send_any;
    logic    send_data;
    logic    send_inst;

    // a spend and a return in the same cycle cancel
    assign credit_next = credit_cnt - credit_t'(pref_valid) + credit_t'(credit_return);

    // send only if a credit is left once this cycle's request is paid for
    assign send_any  = (inst_full || data_full) && (credit_next != '0);
    assign send_data = send_any && data_full;
    assign send_inst = send_any && !data_full;

    // back to back sends stay in SEND, from either state
    assign state_next = send_any ? ISSUE_SEND : ISSUE_IDLE;

    assign pref_valid = (state == ISSUE_SEND);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= ISSUE_IDLE;
            credit_cnt <= credit_t'(L2_CREDITS);
            inst_full  <= 1'b0;
            data_full  <= 1'b0;
        end else begin
            state      <= state_next;
            credit_cnt <= credit_next;
            // a new candidate wins over the clear from a send
            if (inst_cand_valid) begin
                inst_full <= 1'b1;
            end else if (send_inst) begin
                inst_full <= 1'b0;
            end
            if (data_cand_valid) begin
                data_full <= 1'b1;
            end else if (send_data) begin
                data_full <= 1'b0;
            end
        end
    end

    // newest candidate overwrites its slot
    always_ff @(posedge clk) begin
        if (inst_cand_valid) begin
            inst_slot <= inst_cand_addr;
        end
        if (data_cand_valid) begin
            data_slot <= data_cand_addr;
        end
        if (send_any) begin
            pref_addr <= send_data ? data_slot : inst_slot;
            pref_kind <= send_data ? KIND_DATA : KIND_INST;
        end
    end

endmodule

/* design/prefetch_pkg.sv */
// shared sizes, types and encodings for the L1-to-L2 prefetch engine
// every module pulls these in with a wildcard import in its header
package prefetch_pkg;

    localparam int ADDR_W         = 32;
    localparam int LINE_BYTES     = 64;
    localparam int LINE_OFF_W     = $clog2(LINE_BYTES);

    // stride table geometry
    localparam int STRIDE_ENTRIES = 16;
    localparam int IDX_W          = $clog2(STRIDE_ENTRIES);
    localparam int CONF_W         = 2;
    localparam int CONF_ISSUE     = 2;
    localparam int CONF_MAX       = 3;

    // credit flow control toward the L2
    localparam int L2_CREDITS     = 4;
    localparam int CREDIT_W       = 3;

    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic signed [ADDR_W-1:0] stride_t;
    typedef logic [CONF_W-1:0]        conf_t;
    typedef logic [CREDIT_W-1:0]      credit_t;

    // offset bits are set, so no real line start can match it
    localparam addr_t NO_LINE = '1;

    typedef enum logic {
        KIND_INST = 1'b0,
        KIND_DATA = 1'b1
    } pref_kind_e;

    typedef enum logic {
        ISSUE_IDLE = 1'b0,
        ISSUE_SEND = 1'b1
    } issue_state_e;

endpackage

/* design/prefetch_top.sv */
// prefetch engine top level between the L1 caches and the L2
// both predictors feed the issue unit, which talks to the L2
`timescale 1ns/10ps

module prefetch_top
    import prefetch_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       fetch_valid,
    input  addr_t      fetch_addr,
    input  logic       load_valid,
    input  addr_t      load_pc,
    input  addr_t      load_addr,
    input  logic       credit_return,
    output logic       pref_valid,
    output addr_t      pref_addr,
    output pref_kind_e pref_kind
);

    logic  inst_cand_valid;
    addr_t inst_cand_addr;
    logic  data_cand_valid;
    addr_t data_cand_addr;

    next_line_pred u_next_line (
        .clk             (clk),
        .rstn            (rstn),
        .fetch_valid     (fetch_valid),
        .fetch_addr      (fetch_addr),
        .inst_cand_valid (inst_cand_valid),
        .inst_cand_addr  (inst_cand_addr)
    );

    stride_pred u_stride (
        .clk             (clk),
        .rstn            (rstn),
        .load_valid      (load_valid),
        .load_pc         (load_pc),
        .load_addr       (load_addr),
        .data_cand_valid (data_cand_valid),
        .data_cand_addr  (data_cand_addr)
    );

    prefetch_issue u_issue (
        .clk             (clk),
        .rstn            (rstn),
        .inst_cand_valid (inst_cand_valid),
        .inst_cand_addr  (inst_cand_addr),
        .data_cand_valid (data_cand_valid),
        .data_cand_addr  (data_cand_addr),
        .credit_return   (credit_return),
        .pref_valid      (pref_valid),
        .pref_addr       (pref_addr),
        .pref_kind       (pref_kind)
    );

endmodule

/* design/stride_pred.sv */
// data-side stride predictor, one table entry per load PC slice
// a candidate one stride ahead comes out once the stride repeats
`timescale 1ns/10ps

module stride_pred
    import prefetch_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  load_valid,
    input  addr_t load_pc,
    input  addr_t load_addr,
    output logic  data_cand_valid,
    output addr_t data_cand_addr
);

    logic [STRIDE_ENTRIES-1:0] ent_valid;
    addr_t                     ent_last   [STRIDE_ENTRIES];
    stride_t                   ent_stride [STRIDE_ENTRIES];
    conf_t                     ent_conf   [STRIDE_ENTRIES];

    logic [IDX_W-1:0] idx;
    stride_t          new_stride;
    logic             stride_match;
    conf_t            conf_upd;
    logic             issue;

    // word-aligned PC bits pick the entry
    assign idx = load_pc[IDX_W+1:2];

    assign new_stride   = stride_t'(load_addr - ent_last[idx]);
    assign stride_match = (new_stride == ent_stride[idx]) && (new_stride != '0);

    always_comb begin
        if (stride_match) begin
            if (ent_conf[idx] == conf_t'(CONF_MAX)) begin
                conf_upd = ent_conf[idx];
            end else begin
                conf_upd = ent_conf[idx] + 1'b1;
            end
        end else if (new_stride != '0) begin
            // a fresh non-zero stride counts as its first sighting
            conf_upd = conf_t'(1);
        end else begin
            conf_upd = '0;
        end
    end

    // only a trained entry can predict
    assign issue = load_valid && ent_valid[idx] && (conf_upd >= conf_t'(CONF_ISSUE));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ent_valid       <= '0;
            data_cand_valid <= 1'b0;
        end else begin
            data_cand_valid <= issue;
            if (load_valid) begin
                ent_valid[idx] <= 1'b1;
            end
        end
    end

    // table payload, qualified by ent_valid
    always_ff @(posedge clk) begin
        if (load_valid) begin
            ent_last[idx] <= load_addr;
            if (!ent_valid[idx]) begin
                ent_stride[idx] <= '0;
                ent_conf[idx]   <= '0;
            end else begin
                ent_stride[idx] <= new_stride;
                ent_conf[idx]   <= conf_upd;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            data_cand_addr <= addr_t'(load_addr + new_stride);
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# builds the prefetch engine testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module prefetch_tb -f sources.f -Mdir obj_dir
out=$(./obj_dir/Vprefetch_tb) || true
echo "$out"
if echo "$out" | grep -q '^>>> PASS$'; then
    exit 0
fi
exit 1

/* sources.f */
design/prefetch_pkg.sv
design/next_line_pred.sv
design/stride_pred.sv
design/prefetch_issue.sv
design/prefetch_top.sv
tb/prefetch_props.sv
tb/prefetch_tb.sv

/* tb/prefetch_props.sv */
// credit and request rules of the issue unit
// bound into every prefetch_issue instance
`timescale 1ns/10ps

module prefetch_props
    import prefetch_pkg::*;
(
    input logic    clk,
    input logic    rstn,
    input logic    pref_valid,
    input credit_t credit_cnt
);

    credit_range: assert property (@(posedge clk) disable iff (!rstn)
        credit_cnt <= credit_t'(L2_CREDITS))
        else $error("credit count above the L2 grant");

    // a request always has a credit behind it
    send_with_credit: assert property (@(posedge clk) disable iff (!rstn)
        pref_valid |-> (credit_cnt != '0))
        else $error("request sent with no credit left");

    quiet_after_reset: assert property (@(posedge clk) !rstn |=> !pref_valid)
        else $error("request right after reset");

endmodule

bind prefetch_issue prefetch_props u_props (
    .clk        (clk),
    .rstn       (rstn),
    .pref_valid (pref_valid),
    .credit_cnt (credit_cnt)
);

/* tb/prefetch_tb.sv */
// testbench for the prefetch engine, directed cases then a long random run
// every cycle is compared with a reference model, and an L2 model returns the credits
`timescale 1ns/10ps

module prefetch_tb
    import prefetch_pkg::*;
();

    logic       clk;
    logic       rstn;
    logic       fetch_valid;
    addr_t      fetch_addr;
    logic       load_valid;
    addr_t      load_pc;
    addr_t      load_addr;
    logic       credit_return;
    logic       pref_valid;
    addr_t      pref_addr;
    pref_kind_e pref_kind;

    // reference model state, as it stands after the last clock edge
    addr_t      m_last_line, m_ica, m_dca, m_inst_slot, m_data_slot, m_paddr;
    logic       m_icv, m_dcv, m_inst_full, m_data_full, m_pv;
    pref_kind_e m_pkind;
    int         m_credits;
    logic       m_ev [STRIDE_ENTRIES];
    addr_t      m_el [STRIDE_ENTRIES];
    stride_t    m_es [STRIDE_ENTRIES];
    int         m_ec [STRIDE_ENTRIES];

    // L2 side and what was seen at the last edge
    int         ret_due [$];
    int         outstanding;
    int         cycle;
    logic       hold_l2;
    logic       seen_reset;
    logic       seen_pv;
    addr_t      seen_addr;
    pref_kind_e seen_kind;

    prefetch_top u_dut (
        .clk           (clk),
        .rstn          (rstn),
        .fetch_valid   (fetch_valid),
        .fetch_addr    (fetch_addr),
        .load_valid    (load_valid),
        .load_pc       (load_pc),
        .load_addr     (load_addr),
        .credit_return (credit_return),
        .pref_valid    (pref_valid),
        .pref_addr     (pref_addr),
        .pref_kind     (pref_kind)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            abort_run("address mismatch");
        end
    endtask

    task check_kind(input string name, input pref_kind_e got, input pref_kind_e exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            abort_run("request kind mismatch");
        end
    endtask

    task check_valid(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            abort_run("valid mismatch");
        end
    endtask

    task step_model();
        addr_t   nl;
        int      idx;
        stride_t ns;
        int      conf;
        int      avail;
        logic    send;
        logic    pick_data;
        if (!rstn) begin
            m_last_line = '1;
            m_icv       = 1'b0;
            m_dcv       = 1'b0;
            m_inst_full = 1'b0;
            m_data_full = 1'b0;
            m_pv        = 1'b0;
            m_credits   = L2_CREDITS;
            seen_reset  = 1'b1;
            for (int i = 0; i < STRIDE_ENTRIES; i++) begin
                m_ev[i] = 1'b0;
            end
            return;
        end
        // credits left after the request of the cycle that just ended
        avail     = m_credits - int'(m_pv) + int'(credit_return);
        send      = (m_inst_full || m_data_full) && (avail > 0);
        pick_data = m_data_full;
        if (send) begin
            m_paddr = pick_data ? m_data_slot : m_inst_slot;
            m_pkind = pick_data ? KIND_DATA : KIND_INST;
            if (pick_data) begin
                m_data_full = 1'b0;
            end else begin
                m_inst_full = 1'b0;
            end
        end
        m_pv      = send;
        m_credits = avail;
        if (m_icv) begin
            m_inst_full = 1'b1;
            m_inst_slot = m_ica;
        end
        if (m_dcv) begin
            m_data_full = 1'b1;
            m_data_slot = m_dca;
        end
        // next line after the fetched one, repeats dropped
        nl    = (fetch_addr & ~addr_t'(LINE_BYTES - 1)) + addr_t'(LINE_BYTES);
        m_icv = fetch_valid && (nl != m_last_line);
        if (m_icv) begin
            m_last_line = nl;
            m_ica       = nl;
        end
        idx   = int'((load_pc >> 2) % STRIDE_ENTRIES);
        m_dcv = 1'b0;
        if (load_valid) begin
            if (!m_ev[idx]) begin
                m_ev[idx] = 1'b1;
                m_es[idx] = '0;
                m_ec[idx] = 0;
            end else begin
                ns = stride_t'(load_addr - m_el[idx]);
                if (ns == m_es[idx] && ns != 0) begin
                    conf = (m_ec[idx] == 3) ? 3 : m_ec[idx] + 1;
                end else begin
                    // a new non-zero stride counts as seen once
                    conf = (ns != 0) ? 1 : 0;
                end
                m_es[idx] = ns;
                m_ec[idx] = conf;
                if (conf >= CONF_ISSUE) begin
                    m_dcv = 1'b1;
                    m_dca = addr_t'(load_addr + ns);
                end
            end
            m_el[idx] = load_addr;
        end
    endtask

    task tick();
        @(posedge clk);
        seen_pv   = pref_valid;
        seen_addr = pref_addr;
        seen_kind = pref_kind;
        if (rstn && seen_reset) begin
            check_valid("pref_valid", pref_valid, m_pv);
            if (m_pv) begin
                check_addr("pref_addr", pref_addr, m_paddr);
                check_kind("pref_kind", pref_kind, m_pkind);
            end
            if (pref_valid) begin
                outstanding++;
                ret_due.push_back(cycle + 1 + int'($urandom % 8));
            end
        end
        if (credit_return) begin
            outstanding--;
        end
        if (outstanding > L2_CREDITS) begin
            abort_run("the L2 holds more requests than it granted credits");
        end
        step_model();
        cycle++;
        if (!hold_l2 && ret_due.size() != 0 && ret_due[0] <= cycle) begin
            credit_return <= 1'b1;
            void'(ret_due.pop_front());
        end else begin
            credit_return <= 1'b0;
        end
    endtask

    task apply_cycle(input logic fv, input addr_t fa, input logic lv, input addr_t pc,
                     input addr_t la);
        fetch_valid <= fv;
        fetch_addr  <= fa;
        load_valid  <= lv;
        load_pc     <= pc;
        load_addr   <= la;
        tick();
    endtask

    task idle_cycle();
        apply_cycle(1'b0, '0, 1'b0, '0, '0);
    endtask

    task expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            idle_cycle();
            check_valid("pref_valid", seen_pv, 1'b0);
        end
    endtask

    // exp_ticks of zero accepts the request at any cycle
    task wait_request(input int exp_ticks, input addr_t exp_addr, input pref_kind_e exp_kind);
        int n;
        n = 0;
        do begin
            idle_cycle();
            n++;
            if (n > 40) begin
                abort_run("timed out waiting for a prefetch request");
            end
        end while (!seen_pv);
        if (exp_ticks > 0 && n != exp_ticks) begin
            abort_run("prefetch request came at the wrong cycle");
        end
        check_addr("pref_addr", seen_addr, exp_addr);
        check_kind("pref_kind", seen_kind, exp_kind);
    endtask

    task run_random(input int cycles);
        addr_t   fa;
        addr_t   pcs [4];
        addr_t   last [4];
        stride_t strides [4];
        int      k;
        logic    fv;
        logic    lv;
        pcs     = '{32'h104, 32'h108, 32'h10c, 32'h110};
        strides = '{32'sd8, -32'sd64, 32'sd256, 32'sd0};
        last    = '{32'h5000_0000, 32'h6000_0000, 32'h7000_0000, 32'h0};
        fa      = 32'h8000_0000;
        for (int i = 0; i < cycles; i++) begin
            fv = ($urandom % 2) == 0;
            case ($urandom % 4)
                0: fa = $urandom;
                1: fa = fa + addr_t'(LINE_BYTES);
                default: fa = {fa[ADDR_W-1:LINE_OFF_W], LINE_OFF_W'($urandom)};
            endcase
            k  = int'($urandom % 4);
            lv = ($urandom % 3) == 0;
            // the last PC has no pattern at all
            if (lv) begin
                last[k] = (k == 3) ? addr_t'($urandom) : last[k] + addr_t'(strides[k]);
            end
            if (($urandom % 100) == 0) begin
                hold_l2 = !hold_l2;
            end
            apply_cycle(fv, fa, lv, pcs[k], last[k]);
        end
    endtask

    task drain_credits();
        int n;
        hold_l2 = 1'b0;
        n = 0;
        while (outstanding != 0 || m_inst_full || m_data_full || m_icv || m_dcv || m_pv) begin
            idle_cycle();
            n++;
            if (n > 200) begin
                abort_run("timed out waiting for the L2 to return all credits");
            end
        end
    endtask

    initial begin
        void'($urandom(32'hcc9a));
        rstn          = 1'b0;
        fetch_valid   = 1'b0;
        fetch_addr    = '0;
        load_valid    = 1'b0;
        load_pc       = '0;
        load_addr     = '0;
        credit_return = 1'b0;
        hold_l2       = 1'b0;
        seen_reset    = 1'b0;
        outstanding   = 0;
        cycle         = 0;
        m_pv          = 1'b0;
        tick();
        tick();
        rstn <= 1'b1;
        idle_cycle();
        idle_cycle();

        // lone fetch, then more fetches in the same line
        apply_cycle(1'b1, 32'h1000_0010, 1'b0, '0, '0);
        wait_request(3, 32'h1000_0040, KIND_INST);
        apply_cycle(1'b1, 32'h1000_0024, 1'b0, '0, '0);
        apply_cycle(1'b1, 32'h1000_003c, 1'b0, '0, '0);
        expect_quiet(6);

        // stride 0x40 trains on the third load, then a switch to 0x100
        apply_cycle(1'b0, '0, 1'b1, 32'h400, 32'h2000_0000);
        expect_quiet(4);
        apply_cycle(1'b0, '0, 1'b1, 32'h400, 32'h2000_0040);
        expect_quiet(4);
        apply_cycle(1'b0, '0, 1'b1, 32'h400, 32'h2000_0080);
        wait_request(3, 32'h2000_00c0, KIND_DATA);
        apply_cycle(1'b0, '0, 1'b1, 32'h400, 32'h2000_0180);
        expect_quiet(4);
        apply_cycle(1'b0, '0, 1'b1, 32'h400, 32'h2000_0280);
        wait_request(3, 32'h2000_0380, KIND_DATA);

        // both slots fill on the same edge
        apply_cycle(1'b1, 32'h3000_0000, 1'b1, 32'h400, 32'h2000_0380);
        wait_request(3, 32'h2000_0480, KIND_DATA);
        wait_request(0, 32'h3000_0040, KIND_INST);

        // L2 keeps every credit, slots keep only the newest candidate
        hold_l2 = 1'b1;
        for (int i = 0; i < 6; i++) begin
            apply_cycle(1'b1, 32'h4000_0000 + addr_t'(i * LINE_BYTES), 1'b0, '0, '0);
            repeat (3) idle_cycle();
        end
        apply_cycle(1'b0, '0, 1'b1, 32'h400, 32'h2000_0480);
        apply_cycle(1'b0, '0, 1'b1, 32'h400, 32'h2000_0580);
        expect_quiet(6);
        hold_l2 = 1'b0;
        wait_request(0, 32'h2000_0680, KIND_DATA);
        wait_request(0, 32'h4000_0180, KIND_INST);

        run_random(4000);
        drain_credits();
        $display(">>> PASS");
        $finish;
    end

endmodule
